// File: source/p4_router_egress_pkg.sv
//////////////////////////////////////////////////
// Egress router shared definitions
//////////////////////////////////////////////////

`default_nettype none

package p4_router_egress_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int NUM_EGR_PORTS   = 4;
    localparam int EGR_PORT_W      = 2;
    localparam int EGR_BUS_BYTES   = 8;
    localparam int PHYS_PORT_BYTES = 2;
    localparam int LANES_PER_WORD  = EGR_BUS_BYTES / PHYS_PORT_BYTES;

    // Room a buffer needs before a packet is accepted
    localparam int MAX_PKT_WORDS   = 4;
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_CNT_W      = 5;
    localparam int CNT_W           = 16;

    //////////////////////////////////////////////////
    // Types

    typedef logic [EGR_BUS_BYTES*8-1:0]   egr_data_t;
    typedef logic [EGR_BUS_BYTES-1:0]     egr_keep_t;
    typedef logic [EGR_PORT_W-1:0]        egr_port_t;
    typedef logic [PHYS_PORT_BYTES*8-1:0] phys_data_t;
    typedef logic [PHYS_PORT_BYTES-1:0]   phys_keep_t;
    typedef logic [FIFO_CNT_W-1:0]        fifo_cnt_t;
    typedef logic [CNT_W-1:0]             egr_cnt_t;

    // Per-packet routing decision
    typedef enum logic [1:0] {
        pkt_idle,
        pkt_forward,
        pkt_drop
    } pkt_state_t;

endpackage

`default_nettype wire

// File: source/egress_port_fifo.sv
//////////////////////////////////////////////////
// Per-port packet buffer
//////////////////////////////////////////////////

`default_nettype none

module egress_port_fifo
    import p4_router_egress_pkg::*;
(
    input  var logic      egr_bus,
    input  var logic      rst_n,
    input  var logic      wr_en,
    input  var egr_data_t wr_data,
    input  var egr_keep_t wr_keep,
    input  var logic      wr_last,
    input  var logic      rd_ready,
    output logic          rd_valid,
    output egr_data_t     rd_data,
    output egr_keep_t     rd_keep,
    output logic          rd_last,
    output fifo_cnt_t     free_cnt
);

    // Storage, keep and last ride beside each word
    egr_data_t mem_data [FIFO_DEPTH];
    egr_keep_t mem_keep [FIFO_DEPTH];
    logic      mem_last [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_cnt_t                     count;
    logic                          do_rd;

    assign do_rd    = rd_valid && rd_ready;
    assign rd_valid = (count != '0);
    assign rd_data  = mem_data[rd_ptr];
    assign rd_keep  = mem_keep[rd_ptr];
    assign rd_last  = mem_last[rd_ptr];
    assign free_cnt = fifo_cnt_t'(FIFO_DEPTH) - count;

    //////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves count unchanged
            if (wr_en && !do_rd) begin
                count <= count + 1'b1;
            end else if (!wr_en && do_rd) begin
                count <= count - 1'b1;
            end
        end
    end

    // Write port
    always_ff @(posedge egr_bus) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
        end
    end

endmodule

`default_nettype wire

// File: source/egress_width_adapt.sv
//////////////////////////////////////////////////
// 64 to 16 bit width converter
//////////////////////////////////////////////////

`default_nettype none

module egress_width_adapt
    import p4_router_egress_pkg::*;
(
    input  var logic      egr_bus,
    input  var logic      rst_n,
    input  var logic      rd_valid,
    input  var egr_data_t rd_data,
    input  var egr_keep_t rd_keep,
    input  var logic      rd_last,
    input  var logic      out_ready,
    output logic          rd_ready,
    output logic          out_valid,
    output phys_data_t    out_data,
    output phys_keep_t    out_keep,
    output logic          out_last
);

    egr_data_t                         word_q;
    egr_keep_t                         keep_q;
    logic                              last_q;
    logic                              held;
    logic [$clog2(LANES_PER_WORD)-1:0] lane_q;
    logic [$clog2(LANES_PER_WORD)-1:0] lane_nxt;
    logic [$clog2(LANES_PER_WORD)-1:0] lane_first;
    logic [LANES_PER_WORD-1:0]         held_mask;
    logic [LANES_PER_WORD-1:0]         in_mask;
    logic                              final_lane;
    logic                              lane_done;
    logic                              word_done;
    logic                              take;

    // One bit per lane that carries at least one byte
    function automatic logic [LANES_PER_WORD-1:0] lane_mask(input egr_keep_t keep);
        logic [LANES_PER_WORD-1:0] mask;
        for (int l = 0; l < LANES_PER_WORD; l++) begin
            mask[l] = |keep[l*PHYS_PORT_BYTES +: PHYS_PORT_BYTES];
        end
        return mask;
    endfunction

    //////////////////////////////////////////////////
    // Lane selection

    always_comb begin
        held_mask  = lane_mask(keep_q);
        in_mask    = lane_mask(rd_keep);
        final_lane = 1'b1;
        lane_nxt   = lane_q;
        lane_first = '0;
        // Walk downward so the lowest candidate wins
        for (int l = LANES_PER_WORD - 1; l >= 0; l--) begin
            if (l > int'(lane_q) && held_mask[l]) begin
                lane_nxt   = l[$bits(lane_nxt)-1:0];
                final_lane = 1'b0;
            end
            if (in_mask[l]) begin
                lane_first = l[$bits(lane_first)-1:0];
            end
        end
    end

    assign lane_done = held && out_ready;
    assign word_done = lane_done && final_lane;
    assign rd_ready  = !held || word_done;
    assign take      = rd_valid && rd_ready;

    assign out_valid = held;
    assign out_data  = word_q[lane_q*PHYS_PORT_BYTES*8 +: PHYS_PORT_BYTES*8];
    assign out_keep  = keep_q[lane_q*PHYS_PORT_BYTES +: PHYS_PORT_BYTES];
    assign out_last  = last_q && final_lane;

    //////////////////////////////////////////////////
    // Word holding and lane stepping

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            held   <= 1'b0;
            lane_q <= '0;
        end else if (take) begin
            held   <= 1'b1;
            lane_q <= lane_first;
        end else if (word_done) begin
            held <= 1'b0;
        end else if (lane_done) begin
            lane_q <= lane_nxt;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (take) begin
            word_q <= rd_data;
            keep_q <= rd_keep;
            last_q <= rd_last;
        end
    end

endmodule

`default_nettype wire

// File: source/egress_port_counters.sv
//////////////////////////////////////////////////
// Per-port packet counters
//////////////////////////////////////////////////

`default_nettype none

module egress_port_counters
    import p4_router_egress_pkg::*;
(
    input  var logic egr_bus,
    input  var logic rst_n,
    input  var logic fwd_pulse,
    input  var logic drop_pulse,
    input  var logic cnt_clear,
    output egr_cnt_t cnt_fwd,
    output egr_cnt_t cnt_drop
);

    // Saturating step, clear wins over an increment
    function automatic egr_cnt_t cnt_step(
        input egr_cnt_t cur,
        input logic     inc,
        input logic     clr
    );
        egr_cnt_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = '0;
        end else if (inc && (cur != '1)) begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            cnt_fwd  <= '0;
            cnt_drop <= '0;
        end else begin
            cnt_fwd  <= cnt_step(cnt_fwd, fwd_pulse, cnt_clear);
            cnt_drop <= cnt_step(cnt_drop, drop_pulse, cnt_clear);
        end
    end

endmodule

`default_nettype wire

// File: source/egress_port_select.sv
//////////////////////////////////////////////////
// Egress routing and drop control
//////////////////////////////////////////////////

`default_nettype none

module egress_port_select
    import p4_router_egress_pkg::*;
(
    input  var logic                     egr_bus,
    input  var logic                     rst_n,
    input  var logic                     in_valid,
    input  var egr_data_t                in_data,
    input  var egr_keep_t                in_keep,
    input  var logic                     in_last,
    input  var egr_port_t                in_port,
    input  var logic [NUM_EGR_PORTS-1:0] port_enable,
    input  var fifo_cnt_t                free_cnt [NUM_EGR_PORTS],
    output logic [NUM_EGR_PORTS-1:0]     wr_en,
    output egr_data_t                    wr_data,
    output egr_keep_t                    wr_keep,
    output logic                         wr_last,
    output logic [NUM_EGR_PORTS-1:0]     fwd_pulse,
    output logic [NUM_EGR_PORTS-1:0]     drop_pulse,
    output logic [NUM_EGR_PORTS-1:0]     buf_full_drop
);

    pkt_state_t               state_q;
    pkt_state_t               state_d;
    egr_port_t                port_q;
    logic                     first_beat;
    logic                     has_room;
    logic                     fwd_now;
    logic                     cur_fwd;
    egr_port_t                cur_port;
    logic [NUM_EGR_PORTS-1:0] port_sel;
    int                       room;

    //////////////////////////////////////////////////
    // Decision on the first beat

    always_comb begin
        first_beat = in_valid && (state_q == pkt_idle);

        // A write still sitting in the output register is not yet in free_cnt
        room     = int'(free_cnt[in_port]) - int'(wr_en[in_port]);
        has_room = room >= MAX_PKT_WORDS;
        fwd_now  = port_enable[in_port] && has_room;

        // Later beats follow the stored decision
        cur_fwd  = first_beat ? fwd_now : (state_q == pkt_forward);
        cur_port = first_beat ? in_port : port_q;

        port_sel           = '0;
        port_sel[cur_port] = 1'b1;

        state_d = state_q;
        if (first_beat && !in_last) begin
            state_d = fwd_now ? pkt_forward : pkt_drop;
        end else if (in_valid && in_last) begin
            state_d = pkt_idle;
        end
    end

    //////////////////////////////////////////////////
    // Registered steering and pulses

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= pkt_idle;
            port_q        <= '0;
            wr_en         <= '0;
            fwd_pulse     <= '0;
            drop_pulse    <= '0;
            buf_full_drop <= '0;
        end else begin
            state_q <= state_d;
            if (first_beat) begin
                port_q <= in_port;
            end
            wr_en      <= (in_valid && cur_fwd) ? port_sel : '0;
            fwd_pulse  <= (first_beat && fwd_now) ? port_sel : '0;
            drop_pulse <= (first_beat && !fwd_now) ? port_sel : '0;
            // Only a lack of room flags here, a disabled port does not
            buf_full_drop <= (first_beat && port_enable[in_port] && !has_room) ?
                             port_sel : '0;
        end
    end

    // Beat payload shared by all buffers
    always_ff @(posedge egr_bus) begin
        wr_data <= in_data;
        wr_keep <= in_keep;
        wr_last <= in_last;
    end

endmodule

`default_nettype wire

// File: source/p4_router_egress.sv
//////////////////////////////////////////////////
// Egress router top level
//////////////////////////////////////////////////

`default_nettype none

module p4_router_egress
    import p4_router_egress_pkg::*;
(
    input  var logic                     egr_bus,
    input  var logic                     rst_n,

    input  var logic                     in_valid,
    output logic                         in_ready,
    input  var egr_data_t                in_data,
    input  var egr_keep_t                in_keep,
    input  var logic                     in_last,
    input  var egr_port_t                in_port,

    input  var logic [NUM_EGR_PORTS-1:0] port_enable,
    input  var logic [NUM_EGR_PORTS-1:0] cnt_clear,

    output logic [NUM_EGR_PORTS-1:0]     out_valid,
    input  var logic [NUM_EGR_PORTS-1:0] out_ready,
    output logic [NUM_EGR_PORTS-1:0]     out_last,
    output phys_data_t                   out_data [NUM_EGR_PORTS],
    output phys_keep_t                   out_keep [NUM_EGR_PORTS],

    output egr_cnt_t                     cnt_fwd  [NUM_EGR_PORTS],
    output egr_cnt_t                     cnt_drop [NUM_EGR_PORTS],
    output logic [NUM_EGR_PORTS-1:0]     buf_full_drop
);

    logic [NUM_EGR_PORTS-1:0] wr_en;
    egr_data_t                wr_data;
    egr_keep_t                wr_keep;
    logic                     wr_last;
    fifo_cnt_t                free_cnt [NUM_EGR_PORTS];
    logic [NUM_EGR_PORTS-1:0] fwd_pulse;
    logic [NUM_EGR_PORTS-1:0] drop_pulse;

    logic [NUM_EGR_PORTS-1:0] rd_valid;
    logic [NUM_EGR_PORTS-1:0] rd_ready;
    logic [NUM_EGR_PORTS-1:0] rd_last;
    egr_data_t                rd_data [NUM_EGR_PORTS];
    egr_keep_t                rd_keep [NUM_EGR_PORTS];

    // Input stream never back-pressures
    assign in_ready = 1'b1;

    //////////////////////////////////////////////////
    // Routing and drop control

    egress_port_select i_egress_port_select (
        .egr_bus       ( egr_bus       ),
        .rst_n         ( rst_n         ),
        .in_valid      ( in_valid      ),
        .in_data       ( in_data       ),
        .in_keep       ( in_keep       ),
        .in_last       ( in_last       ),
        .in_port       ( in_port       ),
        .port_enable   ( port_enable   ),
        .free_cnt      ( free_cnt      ),
        .wr_en         ( wr_en         ),
        .wr_data       ( wr_data       ),
        .wr_keep       ( wr_keep       ),
        .wr_last       ( wr_last       ),
        .fwd_pulse     ( fwd_pulse     ),
        .drop_pulse    ( drop_pulse    ),
        .buf_full_drop ( buf_full_drop )
    );

    //////////////////////////////////////////////////
    // Port slices

    for (genvar g = 0; g < NUM_EGR_PORTS; g++) begin : g_port
        egress_port_fifo i_egress_port_fifo (
            .egr_bus  ( egr_bus     ),
            .rst_n    ( rst_n       ),
            .wr_en    ( wr_en[g]    ),
            .wr_data  ( wr_data     ),
            .wr_keep  ( wr_keep     ),
            .wr_last  ( wr_last     ),
            .rd_ready ( rd_ready[g] ),
            .rd_valid ( rd_valid[g] ),
            .rd_data  ( rd_data[g]  ),
            .rd_keep  ( rd_keep[g]  ),
            .rd_last  ( rd_last[g]  ),
            .free_cnt ( free_cnt[g] )
        );

        egress_width_adapt i_egress_width_adapt (
            .egr_bus   ( egr_bus      ),
            .rst_n     ( rst_n        ),
            .rd_valid  ( rd_valid[g]  ),
            .rd_data   ( rd_data[g]   ),
            .rd_keep   ( rd_keep[g]   ),
            .rd_last   ( rd_last[g]   ),
            .out_ready ( out_ready[g] ),
            .rd_ready  ( rd_ready[g]  ),
            .out_valid ( out_valid[g] ),
            .out_data  ( out_data[g]  ),
            .out_keep  ( out_keep[g]  ),
            .out_last  ( out_last[g]  )
        );

        egress_port_counters i_egress_port_counters (
            .egr_bus    ( egr_bus       ),
            .rst_n      ( rst_n         ),
            .fwd_pulse  ( fwd_pulse[g]  ),
            .drop_pulse ( drop_pulse[g] ),
            .cnt_clear  ( cnt_clear[g]  ),
            .cnt_fwd    ( cnt_fwd[g]    ),
            .cnt_drop   ( cnt_drop[g]   )
        );
    end

endmodule

`default_nettype wire

// File: bench/p4_router_egress_chk.sv
//////////////////////////////////////////////////
// Egress handshake assertions
//////////////////////////////////////////////////

`default_nettype none

module p4_router_egress_chk
    import p4_router_egress_pkg::*;
(
    input var logic                     egr_bus,
    input var logic                     rst_n,
    input var logic                     in_ready,
    input var logic [NUM_EGR_PORTS-1:0] wr_en,
    input var fifo_cnt_t                free_cnt [NUM_EGR_PORTS],
    input var logic [NUM_EGR_PORTS-1:0] out_valid,
    input var logic [NUM_EGR_PORTS-1:0] out_ready,
    input var logic [NUM_EGR_PORTS-1:0] out_last,
    input var phys_data_t               out_data [NUM_EGR_PORTS],
    input var phys_keep_t               out_keep [NUM_EGR_PORTS]
);

    // Number of failed assertions
    int fail_count = 0;

    assert property (@(posedge egr_bus) disable iff (!rst_n) in_ready)
        else begin
            fail_count++;
            $error("in_ready low outside reset");
        end

    for (genvar p = 0; p < NUM_EGR_PORTS; p++) begin : g_port
        // Payload holds while stalled
        assert property (@(posedge egr_bus) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_data[p])
                && $stable(out_keep[p]) && $stable(out_last[p]))
            else begin
                fail_count++;
                $error("port %0d payload changed under stall", p);
            end

        assert property (@(posedge egr_bus) disable iff (!rst_n)
            wr_en[p] |-> free_cnt[p] != '0)
            else begin
                fail_count++;
                $error("port %0d written while its buffer is full", p);
            end
    end

endmodule

bind p4_router_egress p4_router_egress_chk i_p4_router_egress_chk (
    .egr_bus   ( egr_bus   ),
    .rst_n     ( rst_n     ),
    .in_ready  ( in_ready  ),
    .wr_en     ( wr_en     ),
    .free_cnt  ( free_cnt  ),
    .out_valid ( out_valid ),
    .out_ready ( out_ready ),
    .out_last  ( out_last  ),
    .out_data  ( out_data  ),
    .out_keep  ( out_keep  )
);

`default_nettype wire

// File: bench/p4_router_egress_tb.sv
//////////////////////////////////////////////////
// Egress router testbench
//////////////////////////////////////////////////

`default_nettype none

module p4_router_egress_tb
    import p4_router_egress_pkg::*;
();

    // One expected 16-bit beat on a port
    typedef struct packed {
        phys_data_t data;
        phys_keep_t keep;
        logic       last;
        logic       word_end;
    } beat_t;

    typedef beat_t beat_q_t [$];

    logic                     egr_bus;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_ready;
    egr_data_t                in_data;
    egr_keep_t                in_keep;
    logic                     in_last;
    egr_port_t                in_port;
    logic [NUM_EGR_PORTS-1:0] port_enable;
    logic [NUM_EGR_PORTS-1:0] cnt_clear;
    logic [NUM_EGR_PORTS-1:0] out_valid;
    logic [NUM_EGR_PORTS-1:0] out_ready;
    logic [NUM_EGR_PORTS-1:0] out_last;
    phys_data_t               out_data [NUM_EGR_PORTS];
    phys_keep_t               out_keep [NUM_EGR_PORTS];
    egr_cnt_t                 cnt_fwd  [NUM_EGR_PORTS];
    egr_cnt_t                 cnt_drop [NUM_EGR_PORTS];
    logic [NUM_EGR_PORTS-1:0] buf_full_drop;

    // Reference model state
    beat_t       exp_q      [NUM_EGR_PORTS][$];
    int          acc_words  [NUM_EGR_PORTS];
    int          done_words [NUM_EGR_PORTS];
    int          exp_fwd    [NUM_EGR_PORTS];
    int          exp_drop   [NUM_EGR_PORTS];
    logic        bp_random;
    logic [31:0] lfsr;

    p4_router_egress i_p4_router_egress (.*);

    initial begin
        egr_bus = 1'b0;
        forever begin
            #2 egr_bus = ~egr_bus;
        end
    end

    //////////////////////////////////////////////////
    // Random numbers and reference model

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    // Contiguous keep of 1 to 8 bytes
    function automatic egr_keep_t random_keep();
        int        nbytes;
        egr_keep_t ones;
        nbytes = 1 + int'(rand_bits(3));
        ones   = '1;
        return ones >> (EGR_BUS_BYTES - nbytes);
    endfunction

    // Packet to expected 16-bit beats without empty lanes
    function automatic beat_q_t expect_beats(input egr_data_t words [MAX_PKT_WORDS],
                                             input int len, input egr_keep_t last_keep);
        beat_q_t   beats;
        beat_t     b;
        egr_keep_t keep;
        int        top;
        for (int w = 0; w < len; w++) begin
            keep = (w == len - 1) ? last_keep : '1;
            top  = 0;
            for (int l = 0; l < LANES_PER_WORD; l++) begin
                if (keep[l*PHYS_PORT_BYTES +: PHYS_PORT_BYTES] != '0) begin
                    top = l;
                end
            end
            for (int l = 0; l <= top; l++) begin
                b.keep = keep[l*PHYS_PORT_BYTES +: PHYS_PORT_BYTES];
                if (b.keep != '0) begin
                    b.data     = words[w][l*PHYS_PORT_BYTES*8 +: PHYS_PORT_BYTES*8];
                    b.word_end = (l == top);
                    b.last     = (l == top) && (w == len - 1);
                    beats.push_back(b);
                end
            end
        end
        return beats;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_phys_data(input string name, input int port,
                                   input phys_data_t got, input phys_data_t exp);
        if (got !== exp) begin
            $display("Error: %s[%0d] got 0x%h expected 0x%h", name, port, got, exp);
            stop_run();
        end
    endtask

    task automatic check_phys_keep(input string name, input int port,
                                   input phys_keep_t got, input phys_keep_t exp);
        if (got !== exp) begin
            $display("Error: %s[%0d] got 0x%h expected 0x%h", name, port, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input int port,
                              input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s[%0d] got 0x%h expected 0x%h", name, port, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int port,
                               input egr_cnt_t got, input egr_cnt_t exp);
        if (got !== exp) begin
            $display("Error: %s[%0d] got 0x%h expected 0x%h", name, port, got, exp);
            stop_run();
        end
    endtask

    // Output beats against the model queues
    always @(posedge egr_bus) begin : compare_beats
        beat_t b;
        if (rst_n) begin
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Unexpected output beat on port %0d", p);
                        stop_run();
                    end else begin
                        b = exp_q[p].pop_front();
                        check_phys_data("out_data", p, out_data[p], b.data);
                        check_phys_keep("out_keep", p, out_keep[p], b.keep);
                        check_flag("out_last", p, out_last[p], b.last);
                        if (b.word_end) begin
                            done_words[p]++;
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge egr_bus);
        if (bp_random) begin
            r         = rand_bits(NUM_EGR_PORTS);
            out_ready = r[NUM_EGR_PORTS-1:0];
        end
    endtask

    task automatic send_packet(input egr_port_t port, input int len, input egr_keep_t last_keep);
        egr_data_t   words [MAX_PKT_WORDS];
        beat_q_t     beats;
        logic [31:0] r;
        int          occ;
        logic        fwd;
        logic        full;
        for (int w = 0; w < MAX_PKT_WORDS; w++) begin
            words[w] = {rand_bits(32), rand_bits(32)};
        end
        next_cycle();
        // Outstanding words less the one held in the adapter
        occ = acc_words[port] - done_words[port];
        if (occ > 0) begin
            occ--;
        end
        fwd  = port_enable[port] && (FIFO_DEPTH - occ >= MAX_PKT_WORDS);
        full = port_enable[port] && !fwd;
        if (fwd) begin
            beats = expect_beats(words, len, last_keep);
            foreach (beats[i]) begin
                exp_q[port].push_back(beats[i]);
            end
            acc_words[port] += len;
            exp_fwd[port]++;
        end else begin
            exp_drop[port]++;
        end
        for (int w = 0; w <= len; w++) begin
            if (w > 0) begin
                next_cycle();
            end
            if (w == 1) begin
                check_flag("buf_full_drop", port, buf_full_drop[port], full);
            end
            if (w < len) begin
                r        = rand_bits(EGR_PORT_W);
                in_valid = 1'b1;
                in_data  = words[w];
                in_keep  = (w == len - 1) ? last_keep : '1;
                in_last  = (w == len - 1);
                // Port only matters on the first beat
                in_port  = (w == 0) ? port : r[EGR_PORT_W-1:0];
            end else begin
                in_valid = 1'b0;
                in_last  = 1'b0;
            end
        end
    endtask

    task automatic run_random_packets(input int count);
        logic [31:0] r;
        int          len;
        egr_keep_t   keep;
        for (int i = 0; i < count; i++) begin
            r    = rand_bits(EGR_PORT_W);
            len  = 1 + int'(rand_bits(2));
            keep = random_keep();
            send_packet(r[EGR_PORT_W-1:0], len, keep);
        end
    endtask

    function automatic logic queues_empty();
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!queues_empty()) begin
            if (cycles > 2000) begin
                $display("Timeout waiting for the output ports to drain");
                stop_run();
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic check_counters();
        repeat (2) next_cycle();
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            check_count("cnt_fwd", p, cnt_fwd[p], egr_cnt_t'(exp_fwd[p]));
            check_count("cnt_drop", p, cnt_drop[p], egr_cnt_t'(exp_drop[p]));
        end
    endtask

    task automatic clear_counters();
        next_cycle();
        cnt_clear = '1;
        next_cycle();
        cnt_clear = '0;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            exp_fwd[p]  = 0;
            exp_drop[p] = 0;
        end
        check_counters();
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_port     = '0;
        port_enable = '1;
        cnt_clear   = '0;
        out_ready   = '1;
        bp_random   = 1'b0;
        lfsr        = 32'h184a_b2ec;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            acc_words[p]  = 0;
            done_words[p] = 0;
            exp_fwd[p]    = 0;
            exp_drop[p]   = 0;
        end
        repeat (3) next_cycle();
        rst_n = 1'b1;

        // All ports open and never stalled
        run_random_packets(40);
        wait_drain();
        check_counters();

        // Port 2 disabled
        port_enable = 4'b1011;
        run_random_packets(16);
        wait_drain();
        check_counters();
        clear_counters();
        port_enable = '1;

        // Stalled port 1 fills up
        out_ready[1] = 1'b0;
        repeat (5) send_packet(2'd1, MAX_PKT_WORDS, random_keep());
        out_ready[1] = 1'b1;
        wait_drain();
        check_counters();

        // Random back-pressure everywhere
        bp_random = 1'b1;
        run_random_packets(60);
        bp_random = 1'b0;
        out_ready = '1;
        wait_drain();
        check_counters();

        if (i_p4_router_egress.i_p4_router_egress_chk.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Bound handshake assertions failed");
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: p4_router_egress.f
source/p4_router_egress_pkg.sv
source/egress_port_fifo.sv
source/egress_width_adapt.sv
source/egress_port_counters.sv
source/egress_port_select.sv
source/p4_router_egress.sv
bench/p4_router_egress_chk.sv
bench/p4_router_egress_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the egress router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f p4_router_egress.f --top-module p4_router_egress_tb \
    -o sim_egress || exit 1

# Keep running past assertion errors so the testbench reports them
sim_out=$(./obj_dir/sim_egress +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
